// ==== design/payload_fifo.sv ====
`timescale 1ns/100ps

module payload_fifo (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push,
    input  shtp_pkg::byte_t push_data,
    input  logic            push_last,      // Final byte of its packet
    input  logic            pop,
    output shtp_pkg::byte_t pop_data,
    output logic            pop_last,
    output logic            not_empty,
    output logic            full
);

    import shtp_pkg::*;

    logic [8:0]             mem [FIFO_DEPTH];   // {last, data}
    logic [FIFO_ADDR_W-1:0] wr_ptr;
    logic [FIFO_ADDR_W-1:0] rd_ptr;
    logic [FIFO_ADDR_W:0]   count;              // One extra bit for the full case
    logic                   do_push;
    logic                   do_pop;

    // Status from the count
    assign full      = (count == (FIFO_ADDR_W + 1)'(FIFO_DEPTH));
    assign not_empty = (count != '0);
    assign do_push   = push && !full;           // Overflow is dropped
    assign do_pop    = pop && not_empty;

    // Head entry shows without a read cycle
    assign {pop_last, pop_data} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= {push_last, push_data};
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + FIFO_ADDR_W'(1);
            if (do_pop)  rd_ptr <= rd_ptr + FIFO_ADDR_W'(1);
            case ({do_push, do_pop})
                2'b10:   count <= count + (FIFO_ADDR_W + 1)'(1);
                2'b01:   count <= count - (FIFO_ADDR_W + 1)'(1);
                default: count <= count;    // Both or neither
            endcase
        end
    end

endmodule

// ==== design/report_parser.sv ====
`timescale 1ns/100ps

module report_parser (
    input  logic              clk,
    input  logic              rst_n,
    input  shtp_pkg::byte_t   pop_data,
    input  logic              pop_last,
    input  logic              not_empty,
    input  logic              report_ready,  // System takes the held report
    output logic              pop,
    output logic              quat_valid,
    output shtp_pkg::sample_t quat_w,
    output shtp_pkg::sample_t quat_x,
    output shtp_pkg::sample_t quat_y,
    output shtp_pkg::sample_t quat_z,
    output logic              gyro_valid,
    output shtp_pkg::sample_t gyro_x,
    output shtp_pkg::sample_t gyro_y,
    output shtp_pkg::sample_t gyro_z
);

    import shtp_pkg::*;

    offset_t offset;        // Index of the byte at the FIFO head
    byte_t   report_id;
    byte_t   low_byte;      // LSB waiting for its MSB
    sample_t pair;
    logic    is_rv;
    logic    is_gyro;

    // Stall while any result is held
    assign pop     = not_empty && !quat_valid && !gyro_valid;
    assign pair    = {pop_data, low_byte};      // Little-endian
    assign is_rv   = (report_id == REPORT_ID_ROTATION_VECTOR);
    assign is_gyro = (report_id == REPORT_ID_GYROSCOPE);

    // ==================================================
    // Offset counter and result hold
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            offset     <= '0;
            quat_valid <= 1'b0;
            gyro_valid <= 1'b0;
        end else begin
            if (quat_valid && report_ready) quat_valid <= 1'b0;
            if (gyro_valid && report_ready) gyro_valid <= 1'b0;
            if (pop) begin
                if (pop_last)
                    offset <= '0;                   // Next packet starts at its ID
                else if (offset != '1)
                    offset <= offset + offset_t'(1);    // Saturates on long packets
                // Last field of each report
                if (offset == offset_t'(9) && is_gyro)  gyro_valid <= 1'b1;
                if (offset == offset_t'(11) && is_rv)   quat_valid <= 1'b1;
            end
        end
    end

    // ==================================================
    // Field assembly
    // ==================================================
    // Offsets 1 to 3 are sequence, status and delay, skipped
    always_ff @(posedge clk) begin
        if (pop) begin
            case (offset)
                8'd0:                   report_id <= pop_data;
                8'd4, 8'd6, 8'd8, 8'd10: low_byte <= pop_data;
                8'd5: begin
                    if (is_rv)        quat_x <= pair;
                    else if (is_gyro) gyro_x <= pair;
                end
                8'd7: begin
                    if (is_rv)        quat_y <= pair;
                    else if (is_gyro) gyro_y <= pair;
                end
                8'd9: begin
                    if (is_rv)        quat_z <= pair;
                    else if (is_gyro) gyro_z <= pair;
                end
                8'd11: if (is_rv) quat_w <= pair;   // Real part comes last
                default: ;  // Accuracy and trailing reports ignored
            endcase
        end
    end

endmodule

// ==== design/sensor_hub_top.sv ====
`timescale 1ns/100ps

module sensor_hub_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              int_n,
    input  logic              spi_busy,
    input  logic              spi_rx_valid,
    input  shtp_pkg::byte_t   spi_rx_data,
    input  logic              report_ready,
    output logic              cs_n,
    output logic              spi_start,
    output logic              quat_valid,
    output shtp_pkg::sample_t quat_w,
    output shtp_pkg::sample_t quat_x,
    output shtp_pkg::sample_t quat_y,
    output shtp_pkg::sample_t quat_z,
    output logic              gyro_valid,
    output shtp_pkg::sample_t gyro_x,
    output shtp_pkg::sample_t gyro_y,
    output shtp_pkg::sample_t gyro_z
);

    import shtp_pkg::*;

    // Reader to FIFO
    logic  push;
    byte_t push_data;
    logic  push_last;
    logic  full;
    // FIFO to parser
    logic  pop;
    byte_t pop_data;
    logic  pop_last;
    logic  not_empty;

    shtp_reader u_reader (
        .clk, .rst_n, .int_n, .spi_busy, .spi_rx_valid, .spi_rx_data, .full,
        .cs_n, .spi_start, .push, .push_data, .push_last
    );

    payload_fifo u_fifo (
        .clk, .rst_n, .push, .push_data, .push_last, .pop,
        .pop_data, .pop_last, .not_empty, .full
    );

    report_parser u_parser (
        .clk, .rst_n, .pop_data, .pop_last, .not_empty, .report_ready, .pop,
        .quat_valid, .quat_w, .quat_x, .quat_y, .quat_z,
        .gyro_valid, .gyro_x, .gyro_y, .gyro_z
    );

endmodule

// ==== design/shtp_pkg.sv ====
package shtp_pkg;

    // ==================================================
    // Vector types
    // ==================================================
    typedef logic [7:0]         byte_t;     // One byte on the SPI link
    typedef logic signed [15:0] sample_t;   // Fixed-point sensor component
    typedef logic [14:0]        length_t;   // Packet length, continuation bit dropped
    typedef logic [7:0]         offset_t;   // Index of a payload byte

    // ==================================================
    // SHTP constants
    // ==================================================
    // Header is length LSB, length MSB, channel, sequence
    localparam length_t HEADER_BYTES   = 15'd4;
    localparam length_t MAX_PACKET_LEN = 15'd32766;    // Largest legal SHTP packet

    // Channels that carry input reports
    localparam byte_t CHANNEL_REPORTS = 8'h03;         // Normal input reports
    localparam byte_t CHANNEL_GYRO_RV = 8'h05;         // Gyro-integrated rotation vector

    // Report IDs at payload offset 0
    localparam byte_t REPORT_ID_ROTATION_VECTOR = 8'h05;
    localparam byte_t REPORT_ID_GYROSCOPE       = 8'h02;   // Calibrated gyroscope

    // Payload buffer between reader and parser
    localparam int FIFO_DEPTH  = 8;
    localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

endpackage

// ==== design/shtp_reader.sv ====
`timescale 1ns/100ps

module shtp_reader (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            int_n,          // Hub has a packet, active low
    input  logic            spi_busy,       // Master has taken the start request
    input  logic            spi_rx_valid,   // One-cycle pulse, byte finished
    input  shtp_pkg::byte_t spi_rx_data,
    input  logic            full,           // No room in the payload FIFO
    output logic            cs_n,
    output logic            spi_start,
    output logic            push,
    output shtp_pkg::byte_t push_data,
    output logic            push_last
);

    import shtp_pkg::*;

    typedef enum logic [1:0] {
        st_idle,      // Waiting for int_n
        st_header,    // Four header bytes
        st_payload,   // Payload bytes, kept or dropped
        st_done       // One cycle with cs_n high
    } state_t;

    state_t     state;
    logic       int_meta;       // First synchronizer stage
    logic       int_sync;       // Second stage, safe to use
    logic       in_flight;      // Byte started, rx_valid still due
    logic       byte_done;
    logic       can_start;
    logic [1:0] hdr_idx;        // Which header byte comes next
    length_t    length;
    length_t    remaining;      // Payload bytes still to read
    logic       keep;           // Channel carries reports
    logic       bad_length;

    // ==================================================
    // Interrupt synchronizer
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_meta <= 1'b1;   // Idle level of int_n
            int_sync <= 1'b1;
        end else begin
            int_meta <= int_n;
            int_sync <= int_meta;
        end
    end

    // ==================================================
    // SPI byte handshake
    // ==================================================
    assign byte_done = spi_rx_valid && in_flight;   // Ignore stray pulses

    // Push in progress counts as a taken slot until full catches up
    assign can_start = (state == st_header || state == st_payload) && !cs_n &&
                       !in_flight && !full && !push;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spi_start <= 1'b0;
            in_flight <= 1'b0;
        end else begin
            if (spi_start) begin
                if (spi_busy) spi_start <= 1'b0;    // Master saw it, release
            end else if (can_start) begin
                spi_start <= 1'b1;                  // Held until busy
                in_flight <= 1'b1;
            end
            if (byte_done) in_flight <= 1'b0;
        end
    end

    // ==================================================
    // Packet FSM
    // ==================================================
    assign bad_length = (length <= HEADER_BYTES) || (length > MAX_PACKET_LEN);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            cs_n      <= 1'b1;
            hdr_idx   <= 2'd0;
            length    <= '0;
            remaining <= '0;
            keep      <= 1'b0;
            push      <= 1'b0;
        end else begin
            push <= 1'b0;   // Single-cycle strobe
            case (state)
                st_idle: begin
                    hdr_idx <= 2'd0;
                    if (!int_sync) begin
                        cs_n  <= 1'b0;      // Select the hub
                        state <= st_header;
                    end
                end
                st_header: begin
                    if (byte_done) begin
                        hdr_idx <= hdr_idx + 2'd1;
                        case (hdr_idx)
                            2'd0: length[7:0]  <= spi_rx_data;
                            2'd1: length[14:8] <= spi_rx_data[6:0];  // Bit 15 is continuation
                            2'd2: keep <= (spi_rx_data == CHANNEL_REPORTS) ||
                                          (spi_rx_data == CHANNEL_GYRO_RV);
                            default: begin
                                // Sequence byte, length is complete now
                                remaining <= length - HEADER_BYTES;
                                if (bad_length) begin
                                    cs_n  <= 1'b1;  // Nothing more to clock
                                    state <= st_done;
                                end else begin
                                    state <= st_payload;
                                end
                            end
                        endcase
                    end
                end
                st_payload: begin
                    if (byte_done) begin
                        push      <= keep;  // Other channels are read and dropped
                        remaining <= remaining - length_t'(1);
                        if (remaining == length_t'(1)) begin
                            cs_n  <= 1'b1;
                            state <= st_done;
                        end
                    end
                end
                default: state <= st_idle;  // st_done, gap before next packet
            endcase
        end
    end

    // Payload byte and its end flag, valid with push
    always_ff @(posedge clk) begin
        if (state == st_payload && byte_done) begin
            push_data <= spi_rx_data;
            push_last <= (remaining == length_t'(1));
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the sensor hub testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module sensor_hub_tb -f sensor_hub_top.f -o sensor_hub_sim
./obj_dir/sensor_hub_sim | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi

// ==== sensor_hub_top.f ====
design/shtp_pkg.sv
design/shtp_reader.sv
design/payload_fifo.sv
design/report_parser.sv
design/sensor_hub_top.sv
tb/sensor_hub_assert.sv
tb/sensor_hub_tb.sv

// ==== tb/sensor_hub_assert.sv ====
`timescale 1ns/100ps

module sensor_hub_assert (
    input logic              clk,
    input logic              rst_n,
    input logic              cs_n,
    input logic              spi_start,
    input logic              report_ready,
    input logic              quat_valid,
    input shtp_pkg::sample_t quat_w,
    input shtp_pkg::sample_t quat_x,
    input shtp_pkg::sample_t quat_y,
    input shtp_pkg::sample_t quat_z,
    input logic              gyro_valid,
    input shtp_pkg::sample_t gyro_x,
    input shtp_pkg::sample_t gyro_y,
    input shtp_pkg::sample_t gyro_z
);

    // ==================================================
    // SPI side
    // ==================================================
    start_needs_cs: assert property (@(posedge clk) disable iff (!rst_n)
        spi_start |-> !cs_n) else $error("spi_start high while cs_n is high");

    // ==================================================
    // Report side
    // ==================================================
    one_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !(quat_valid && gyro_valid)) else $error("quat_valid and gyro_valid both high");

    // Held report keeps its values until accepted
    quat_hold: assert property (@(posedge clk) disable iff (!rst_n)
        quat_valid && !report_ready |=> quat_valid && $stable({quat_w, quat_x, quat_y, quat_z}))
        else $error("Rotation vector changed before report_ready");

    gyro_hold: assert property (@(posedge clk) disable iff (!rst_n)
        gyro_valid && !report_ready |=> gyro_valid && $stable({gyro_x, gyro_y, gyro_z}))
        else $error("Gyroscope report changed before report_ready");

endmodule

bind sensor_hub_top sensor_hub_assert u_assert (
    .clk, .rst_n, .cs_n, .spi_start, .report_ready,
    .quat_valid, .quat_w, .quat_x, .quat_y, .quat_z,
    .gyro_valid, .gyro_x, .gyro_y, .gyro_z
);

// ==== tb/sensor_hub_patterns.txt ====
# name kind v0 v1 v2 v3 hold xfer nbytes bytes... (hex v = w x y z for quat, x y z 0 for gyro)
# kind quat, gyro or none; hold = report_ready low cycles; xfer = bytes before cs_n rises
rv_ch3 quat 7fff 1234 f00d 0102 0 18 18 12 00 03 01 05 00 03 00 34 12 0d f0 02 01 ff 7f 10 00
gyro_ch5 gyro ff80 0040 8001 0000 0 14 14 0e 00 05 02 02 01 03 00 80 ff 40 00 01 80
chan2_drop none 0 0 0 0 0 10 10 0a 00 02 03 05 00 03 00 11 22
short_len none 0 0 0 0 0 4 4 04 00 03 04
big_len none 0 0 0 0 0 4 4 ff ff 03 05
cont_bit quat c000 0001 fffe 4000 0 18 18 12 80 03 06 05 00 03 00 01 00 fe ff 00 40 00 c0 00 00
hold_long quat 1020 0a0b 0c0d 0e0f 40 20 20 14 00 03 07 05 02 03 00 0b 0a 0d 0c 0f 0e 20 10 01 02 03 04
hold_second gyro 1111 2222 dead 0000 0 14 14 0e 00 03 08 02 03 03 00 11 11 22 22 ad de

// ==== tb/sensor_hub_tb.sv ====
`timescale 1ns/100ps

module sensor_hub_tb;

    import shtp_pkg::*;

    typedef logic [8*16-1:0] name_t;    // Test name from the patterns
    typedef logic [63:0]     vals_t;    // Four components, first on top

    localparam int SEED        = 41790;
    localparam int BYTE_WAIT   = 4000;  // Cycles with no SPI progress
    localparam int REPORT_WAIT = 2000;

    logic    clk;
    logic    rst_n;
    logic    int_n;
    logic    spi_busy;
    logic    spi_rx_valid;
    byte_t   spi_rx_data;
    logic    report_ready;
    logic    cs_n;
    logic    spi_start;
    logic    quat_valid;
    logic    gyro_valid;
    sample_t quat_w, quat_x, quat_y, quat_z;
    sample_t gyro_x, gyro_y, gyro_z;

    int          errors = 0;
    int          tests = 0;
    int          hold_cycles = 0;   // report_ready low time for the next report
    int          reports_sent = 0;
    int          reports_done = 0;
    bit          timed_out = 1'b0;
    name_t       exp_name[$];       // Expected reports, in arrival order
    logic [31:0] exp_kind[$];
    vals_t       exp_vals[$];

    sensor_hub_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 100 MHz
    end

    // ==================================================
    // Compare tasks
    // ==================================================
    task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail %0s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail %0s: expected %0d bytes, actual %0d", name, expected, actual);
        end
    endtask

    function automatic vals_t current_vals(input logic is_quat);
        return is_quat ? {quat_w, quat_x, quat_y, quat_z} : {gyro_x, gyro_y, gyro_z, 16'h0000};
    endfunction

    // ==================================================
    // SPI byte master model
    // ==================================================
    task automatic serve_byte(input byte_t data);
        int delay;
        delay = $urandom_range(4, 1);   // Busy after 1 to 4 cycles
        repeat (delay) @(posedge clk);
        spi_busy <= 1'b1;
        @(posedge clk);
        spi_busy     <= 1'b0;
        spi_rx_valid <= 1'b1;           // Byte finished
        spi_rx_data  <= data;
        @(posedge clk);
        spi_rx_valid <= 1'b0;
    endtask

    // One interrupt, then bytes until cs_n rises
    task automatic send_packet(input byte_t pkt[$], output int sent);
        int idle;
        sent = 0;
        idle = 0;
        @(posedge clk);
        int_n <= 1'b0;
        do begin
            @(negedge clk);
            idle++;
        end while (cs_n && idle < BYTE_WAIT);
        if (cs_n) begin
            timed_out = 1'b1;
            errors++;
            $display("cs_n did not fall after int_n went low");
        end
        @(posedge clk);
        int_n <= 1'b1;                  // Released well before the packet ends
        idle = 0;
        while (!cs_n && idle < BYTE_WAIT) begin
            @(negedge clk);
            if (spi_start) begin
                serve_byte(sent < pkt.size() ? pkt[sent] : 8'h00);
                sent++;
                idle = 0;
            end else begin
                idle++;                 // Stalls on a full FIFO count here
            end
        end
        if (idle >= BYTE_WAIT) begin
            timed_out = 1'b1;
            errors++;
            $display("SPI transfer stalled, cs_n never rose");
        end
    endtask

    task automatic wait_reports();
        int cycles;
        cycles = 0;
        while (reports_done < reports_sent && cycles < REPORT_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        if (reports_done < reports_sent) begin
            timed_out = 1'b1;
            errors++;
            $display("Expected report did not arrive within %0d cycles", REPORT_WAIT);
        end
    endtask

    // ==================================================
    // Report receiver
    // ==================================================
    initial begin : receiver
        vals_t       held;
        vals_t       expected;
        name_t       tname;
        logic [31:0] tkind;
        logic        is_quat;
        logic        moved;
        int          e0;
        int          hold;
        report_ready <= 1'b0;
        forever begin
            @(negedge clk);
            if (quat_valid || gyro_valid) begin
                is_quat = quat_valid;
                held    = current_vals(is_quat);
                hold    = hold_cycles;  // Latched, main moves on meanwhile
                moved   = 1'b0;
                e0      = errors;
                repeat (hold) begin
                    @(negedge clk);
                    if (current_vals(is_quat) !== held || (is_quat ? !quat_valid : !gyro_valid))
                        moved = 1'b1;
                end
                @(posedge clk);
                report_ready <= 1'b1;   // Accept for one cycle
                @(posedge clk);
                report_ready <= 1'b0;
                if (exp_name.size() == 0) begin
                    errors++;
                    $display("A report arrived where none was expected");
                end else begin
                    tname    = exp_name.pop_front();
                    tkind    = exp_kind.pop_front();
                    expected = exp_vals.pop_front();
                    if (moved) begin
                        errors++;
                        $display("%0s: report changed while report_ready was low", tname);
                    end
                    if (is_quat != (tkind == "quat")) begin
                        errors++;
                        $display("%0s: the report came out as the wrong kind", tname);
                    end
                    for (int k = 0; k < 4; k++)
                        check_sample($sformatf("%0s component %0d", tname, k),
                                     expected[63 - 16*k -: 16], held[63 - 16*k -: 16]);
                    $display("%0s: %0s", tname, (errors == e0) ? "ok" : "check failed");
                end
                reports_done++;
            end
        end
    end

    // ==================================================
    // Pattern replay
    // ==================================================
    initial begin : main
        int               fd;
        int               hold;
        int               xfer;
        int               nbytes;
        int               sent;
        int               e0;
        name_t            name;
        logic [31:0]      kind;
        sample_t          v0, v1, v2, v3;
        byte_t            b;
        byte_t            pkt[$];
        logic [8*200-1:0] text;
        void'($urandom(SEED));
        rst_n        <= 1'b0;
        int_n        <= 1'b1;
        spi_busy     <= 1'b0;
        spi_rx_valid <= 1'b0;
        spi_rx_data  <= 8'h00;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        fd = $fopen("tb/sensor_hub_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open tb/sensor_hub_patterns.txt");
        end else begin
            void'($fgets(text, fd));    // Column description
            void'($fgets(text, fd));
            while (!timed_out && $fscanf(fd, "%s %s %h %h %h %h %d %d %d", name, kind,
                                         v0, v1, v2, v3, hold, xfer, nbytes) == 9) begin
                pkt.delete();
                repeat (nbytes) begin
                    void'($fscanf(fd, "%h", b));
                    pkt.push_back(b);
                end
                tests++;
                e0 = errors;
                if (kind != "none") begin
                    exp_name.push_back(name);
                    exp_kind.push_back(kind);
                    exp_vals.push_back({v0, v1, v2, v3});
                    reports_sent++;
                end
                hold_cycles = hold;
                send_packet(pkt, sent);
                check_count($sformatf("%0s", name), byte_t'(xfer), byte_t'(sent));
                if (kind == "none")
                    $display("%0s: %0s", name, (errors == e0) ? "ok" : "check failed");
                if (hold == 0 && !timed_out)
                    wait_reports();     // A held report is checked with the next one
            end
            $fclose(fd);
        end
        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
